// ==== sam_settings.svh ====
// Port addresses and timing constants shared by the I/O subsystem RTL, pulled in by `include
`ifndef SAM_SETTINGS_SVH
`define SAM_SETTINGS_SVH

// ==============================
// ASIC port addresses (low byte)
// ==============================
`define SAM_PORT_LMPR 8'hFA
`define SAM_PORT_HMPR 8'hFB
`define SAM_PORT_BRDR 8'hFE
`define SAM_PORT_STAT 8'hF9
`define SAM_PORT_MIDI 8'hFD
`define SAM_PORT_LPTD 8'hE8
`define SAM_PORT_LPTS 8'hE9
`define SAM_PORT_EXTC 8'h80
`define SAM_PORT_EXTD 8'h81

// ==============================
// Timing
// ==============================
`define SAM_TICK_DIV 96
`define SAM_MIDI_BIT_TICKS 320
`define SAM_MIDI_INT_AT 15

`endif

// ==== sam_pkg.sv ====
// Shared bus, memory map and port write types plus enums for the I/O subsystem modules
package sam_pkg;

	// CPU side, all levels active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        port_we;
		logic        mreq;
		logic        rd;
		logic        wr;
	} cpu_bus_t;

	typedef struct packed {
		logic [8:0] ram_page;
		logic       rom0_sel;
		logic       rom1_sel;
		logic       ram_we;
		logic       ram_rd;
	} mem_map_t;

	typedef struct packed {
		logic [7:0] lmpr;
		logic [7:0] hmpr;
		logic [7:0] ext_c;
		logic [7:0] ext_d;
		logic       ext_dis;
	} page_regs_t;

	// One-cycle write pulses with the byte written
	typedef struct packed {
		logic       midi_wr;
		logic       lptd_wr;
		logic       lpts_wr;
		logic [7:0] data;
	} port_wr_t;

	typedef enum logic [3:0] {
		PORT_NONE,
		PORT_LMPR,
		PORT_HMPR,
		PORT_BRDR,
		PORT_STAT,
		PORT_MIDI,
		PORT_LPTD,
		PORT_LPTS,
		PORT_EXTC,
		PORT_EXTD
	} asic_port_e;

	typedef enum logic {
		MIDI_IDLE,
		MIDI_SEND
	} midi_state_e;

endpackage

// ==== sam_timebase.sv ====
// Divides clk_sys down to a one-cycle 1 MHz tick for the MIDI timer and the SID muter
`timescale 1ns/1ps
`include "sam_settings.svh"

module sam_timebase (
	input  logic clk_sys,
	input  logic reset,
	output logic tick
);

	localparam int unsigned DIV = `SAM_TICK_DIV;
	localparam int CW = $clog2(DIV);

	logic [CW-1:0] div_cnt;

	// Tick lands on the last count of each period
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end else if (div_cnt == CW'(DIV - 1)) begin
			div_cnt <= '0;
			tick    <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			tick    <= 1'b0;
		end
	end

	a_tick_single: assert property (@(posedge clk_sys) disable iff (reset) tick |=> !tick)
		else $error("tick high on two consecutive cycles");

endmodule

// ==== asic_ports.sv ====
// ASIC port decode, paging/border/ext-RAM registers and port readback for the CPU
`timescale 1ns/1ps
`include "sam_settings.svh"

module asic_ports (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                ext_ram_off,
	input  sam_pkg::cpu_bus_t   bus,
	input  logic                midi_int,
	output sam_pkg::page_regs_t regs,
	output sam_pkg::port_wr_t   pwr,
	output logic                ear,
	output logic [7:0]          asic_dout
);

	import sam_pkg::*;

	asic_port_e port_sel;
	logic       port_we_q;
	logic       wr_edge;
	logic [7:0] brdr;

	always_comb begin
		case (bus.addr[7:0])
			`SAM_PORT_LMPR: port_sel = PORT_LMPR;
			`SAM_PORT_HMPR: port_sel = PORT_HMPR;
			`SAM_PORT_BRDR: port_sel = PORT_BRDR;
			`SAM_PORT_STAT: port_sel = PORT_STAT;
			`SAM_PORT_MIDI: port_sel = PORT_MIDI;
			`SAM_PORT_LPTD: port_sel = PORT_LPTD;
			`SAM_PORT_LPTS: port_sel = PORT_LPTS;
			`SAM_PORT_EXTC: port_sel = PORT_EXTC;
			`SAM_PORT_EXTD: port_sel = PORT_EXTD;
			default:        port_sel = PORT_NONE;
		endcase
	end

	// Write strobe is a level, act on its rising edge only
	assign wr_edge = bus.port_we & ~port_we_q;

	// ==============================
	// Registers
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (wr_edge)
			pwr.data <= bus.dout;
		if (reset) begin
			port_we_q    <= 1'b0;
			regs.lmpr    <= '0;
			regs.hmpr    <= '0;
			brdr         <= '0;
			regs.ext_dis <= ext_ram_off;
			pwr.midi_wr  <= 1'b0;
			pwr.lptd_wr  <= 1'b0;
			pwr.lpts_wr  <= 1'b0;
		end else begin
			port_we_q   <= bus.port_we;
			pwr.midi_wr <= wr_edge && (port_sel == PORT_MIDI);
			pwr.lptd_wr <= wr_edge && (port_sel == PORT_LPTD);
			pwr.lpts_wr <= wr_edge && (port_sel == PORT_LPTS);
			if (wr_edge) begin
				case (port_sel)
					PORT_LMPR: regs.lmpr  <= bus.dout;
					PORT_HMPR: regs.hmpr  <= bus.dout;
					PORT_BRDR: brdr       <= bus.dout;
					PORT_EXTC: regs.ext_c <= bus.dout;
					PORT_EXTD: regs.ext_d <= bus.dout;
					default: ;
				endcase
			end
		end
	end

	assign ear = brdr[4];

	// ==============================
	// Readback
	// ==============================
	always_comb begin
		case (port_sel)
			PORT_LMPR: asic_dout = regs.lmpr;
			PORT_HMPR: asic_dout = regs.hmpr;
			// Keyboard, frame and line bits read inactive
			PORT_STAT: asic_dout = {3'b111, ~midi_int, 4'b1111};
			PORT_LPTD,
			PORT_LPTS: asic_dout = 8'h00;
			default:   asic_dout = 8'hFF;
		endcase
	end

endmodule

// ==== mem_mapper.sv ====
// Maps each CPU address onto a RAM page, ROM select and RAM read/write enables
`timescale 1ns/1ps

module mem_mapper (
	input  sam_pkg::cpu_bus_t   bus,
	input  sam_pkg::page_regs_t regs,
	output sam_pkg::mem_map_t   map
);

	logic [1:0] section;
	logic       ext_ram;
	logic       ram_wp;
	logic       ext_ena;
	logic [4:0] page_ab;
	logic [4:0] page_cd;

	assign section = bus.addr[15:14];
	assign page_ab = regs.lmpr[4:0];
	assign page_cd = regs.hmpr[4:0];

	// Upper 32K goes to external RAM when HMPR bit 7 is set
	assign ext_ram = regs.hmpr[7] & bus.addr[15];
	assign ram_wp  = regs.lmpr[7] & (section == 2'd0);
	assign ext_ena = ~(ext_ram & regs.ext_dis);

	assign map.rom0_sel = ~regs.lmpr[5] & (section == 2'd0);
	assign map.rom1_sel = regs.lmpr[6] & (section == 2'd3);

	always_comb begin
		if (ext_ram)
			map.ram_page = section[0] ? {1'b1, regs.ext_d} : {1'b1, regs.ext_c};
		else begin
			case (section)
				2'd0:    map.ram_page = {4'b0000, page_ab};
				2'd1:    map.ram_page = {4'b0000, page_ab + 5'd1};
				2'd2:    map.ram_page = {4'b0000, page_cd};
				default: map.ram_page = {4'b0000, page_cd + 5'd1};
			endcase
		end
	end

	assign map.ram_rd = bus.mreq & bus.rd & ~map.rom0_sel & ~map.rom1_sel;
	assign map.ram_we = bus.mreq & bus.wr & ~map.rom0_sel & ~map.rom1_sel & ~ram_wp & ext_ena;

	// ROM space is never written through to RAM
	always_comb begin
		a_no_rom_write: assert (!(map.ram_we && ((!regs.lmpr[5] && bus.addr[15:14] == 2'd0)
				|| (regs.lmpr[6] && bus.addr[15:14] == 2'd3))))
			else $error("ram_we asserted inside a ROM section");
	end

endmodule

// ==== midi_tx.sv ====
// Times one MIDI byte transmission in 1 MHz ticks and raises the MIDI interrupt near its end
`timescale 1ns/1ps
`include "sam_settings.svh"

module midi_tx (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              tick,
	input  sam_pkg::port_wr_t pwr,
	output logic              midi_int,
	output logic              midi_out
);

	import sam_pkg::*;

	localparam logic [8:0] LOAD_TICKS = 9'(`SAM_MIDI_BIT_TICKS - 1);
	localparam logic [8:0] INT_AT     = 9'(`SAM_MIDI_INT_AT);

	midi_state_e state;
	logic        pending;
	logic [8:0]  tx_time;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= MIDI_IDLE;
			pending  <= 1'b0;
			tx_time  <= '0;
			midi_int <= 1'b0;
		end else begin
			if (tick) begin
				case (state)
					MIDI_IDLE: begin
						if (pending) begin
							state   <= MIDI_SEND;
							tx_time <= LOAD_TICKS;
							pending <= 1'b0;
						end
					end
					MIDI_SEND: begin
						if (tx_time != '0) begin
							tx_time <= tx_time - 1'b1;
							if (tx_time == INT_AT)
								midi_int <= 1'b1;
						end else begin
							// Byte done, line and interrupt drop together
							state    <= MIDI_IDLE;
							midi_int <= 1'b0;
						end
					end
					default: state <= MIDI_IDLE;
				endcase
			end
			// New write queues behind any byte in flight
			if (pwr.midi_wr)
				pending <= 1'b1;
		end
	end

	assign midi_out = (state == MIDI_SEND);

	a_int_in_send: assert property (@(posedge clk_sys) disable iff (reset) midi_int |-> midi_out)
		else $error("midi_int high while midi_out low");

endmodule

// ==== lpt_dac.sv ====
// Printer-port voice DAC, latches the data byte and routes it left or right on strobe edges
`timescale 1ns/1ps

module lpt_dac (
	input  logic              clk_sys,
	input  logic              reset,
	input  sam_pkg::port_wr_t pwr,
	output logic [7:0]        vox_l,
	output logic [7:0]        vox_r
);

	logic [7:0] lpt_data;
	logic       stb_q;

	always_ff @(posedge clk_sys) begin
		if (pwr.lptd_wr)
			lpt_data <= pwr.data;
	end

	// Rising strobe feeds the left channel, falling strobe the right
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vox_l <= '0;
			vox_r <= '0;
			stb_q <= 1'b0;
		end else if (pwr.lpts_wr) begin
			if (~stb_q & pwr.data[0])
				vox_l <= lpt_data;
			if (stb_q & ~pwr.data[0])
				vox_r <= lpt_data;
			stb_q <= pwr.data[0];
		end
	end

endmodule

// ==== audio_mixer.sv ====
// Sums PSG, border ear, voice DAC and soft-muted SID into the 16-bit stereo outputs
`timescale 1ns/1ps

module audio_mixer (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               tick,
	input  logic               ear,
	input  logic               sid_active,
	input  logic [7:0]         psg_l,
	input  logic [7:0]         psg_r,
	input  logic [7:0]         vox_l,
	input  logic [7:0]         vox_r,
	input  logic signed [17:0] sid_sample,
	output logic [15:0]        audio_l,
	output logic [15:0]        audio_r
);

	logic [17:0] att;
	logic [17:0] sid_offset;
	logic [17:0] sid_muted;
	logic [18:0] mix_l;
	logic [18:0] mix_r;

	// One channel's sum, shared by left and right
	function automatic logic [18:0] mix_sum(input logic [7:0] psg, input logic [7:0] vox,
			input logic ear_bit, input logic [17:0] sid);
		mix_sum = {1'b0, psg, psg, 2'b00} + {1'b0, ear_bit, 17'd0}
			+ {1'b0, vox, vox, 2'b00} + {1'b0, sid};
	endfunction

	// ==============================
	// SID soft mute
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset)
			att <= '1;
		else if (tick) begin
			if (sid_active && (att != '0))
				att <= att - 1'b1;
			if (!sid_active && !(&att))
				att <= att + 1'b1;
		end
	end

	// Signed sample to offset binary
	assign sid_offset = {~sid_sample[17], sid_sample[16:0]};
	assign sid_muted  = (sid_offset > att) ? sid_offset - att : 18'd0;

	assign mix_l = mix_sum(psg_l, vox_l, ear, sid_muted);
	assign mix_r = mix_sum(psg_r, vox_r, ear, sid_muted);

	assign audio_l = mix_l[18:3];
	assign audio_r = mix_r[18:3];

endmodule

// ==== sam_io_top.sv ====
// Top level of the I/O subsystem, wires the ports, mapper, MIDI, voice DAC and mixer together
`timescale 1ns/1ps

module sam_io_top (
	input  logic               clk_sys,
	input  logic               reset,
	input  sam_pkg::cpu_bus_t  bus,
	input  logic               ext_ram_off,
	input  logic [7:0]         psg_l,
	input  logic [7:0]         psg_r,
	input  logic signed [17:0] sid_sample,
	input  logic               sid_active,
	output logic [7:0]         asic_dout,
	output sam_pkg::mem_map_t  map,
	output logic               midi_int,
	output logic               midi_out,
	output logic [15:0]        audio_l,
	output logic [15:0]        audio_r
);

	import sam_pkg::*;

	page_regs_t regs;
	port_wr_t   pwr;
	logic       tick;
	logic       ear;
	logic [7:0] vox_l;
	logic [7:0] vox_r;

	sam_timebase timebase_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.tick    (tick)
	);

	asic_ports ports_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ext_ram_off (ext_ram_off),
		.bus         (bus),
		.midi_int    (midi_int),
		.regs        (regs),
		.pwr         (pwr),
		.ear         (ear),
		.asic_dout   (asic_dout)
	);

	mem_mapper mapper_i (
		.bus  (bus),
		.regs (regs),
		.map  (map)
	);

	midi_tx midi_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.tick     (tick),
		.pwr      (pwr),
		.midi_int (midi_int),
		.midi_out (midi_out)
	);

	lpt_dac dac_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pwr     (pwr),
		.vox_l   (vox_l),
		.vox_r   (vox_r)
	);

	audio_mixer mixer_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.tick       (tick),
		.ear        (ear),
		.sid_active (sid_active),
		.psg_l      (psg_l),
		.psg_r      (psg_r),
		.vox_l      (vox_l),
		.vox_r      (vox_r),
		.sid_sample (sid_sample),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

endmodule

// ==== tb_sam_io.sv ====
// Self-checking testbench for sam_io_top, applies a table of port, paging, audio and MIDI steps
`timescale 1ns/1ps

module tb_sam_io;

	import sam_pkg::*;

	typedef enum {OP_WRITE, OP_READ, OP_PROBE, OP_AUDIO, OP_RESET, OP_MIDI} op_e;

	// One step of the table, exp holds the expected response
	typedef struct {
		op_e         op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [15:0] exp;
	} row_t;

	logic               clk_sys;
	logic               reset;
	cpu_bus_t           bus;
	logic               ext_ram_off;
	logic [7:0]         psg_l;
	logic [7:0]         psg_r;
	logic signed [17:0] sid_sample;
	logic               sid_active;
	logic [7:0]         asic_dout;
	mem_map_t           map;
	logic               midi_int;
	logic               midi_out;
	logic [15:0]        audio_l;
	logic [15:0]        audio_r;

	row_t rows[$];
	int   checks;
	int   errors;
	int   limit_cycles;

	// Reference state, tracked while the table is built
	logic [7:0] m_lmpr;
	logic [7:0] m_hmpr;
	logic [7:0] m_brdr;
	logic [7:0] m_extc;
	logic [7:0] m_extd;
	logic       m_ext_dis;
	logic [7:0] m_lptd;
	logic       m_stb;
	logic [7:0] m_vox_l;
	logic [7:0] m_vox_r;

	sam_io_top dut_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (bus),
		.ext_ram_off (ext_ram_off),
		.psg_l       (psg_l),
		.psg_r       (psg_r),
		.sid_sample  (sid_sample),
		.sid_active  (sid_active),
		.asic_dout   (asic_dout),
		.map         (map),
		.midi_int    (midi_int),
		.midi_out    (midi_out),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ==============================
	// Reference rules
	// ==============================
	function automatic logic [12:0] map_model(input logic [15:0] a, input logic rd,
			input logic wr);
		logic [1:0] sec;
		logic       ext;
		logic       rom0;
		logic       rom1;
		logic       wp;
		logic [4:0] base;
		logic [8:0] page;
		sec  = a[15:14];
		ext  = m_hmpr[7] && a[15];
		rom0 = !m_lmpr[5] && (sec == 2'd0);
		rom1 = m_lmpr[6] && (sec == 2'd3);
		wp   = m_lmpr[7] && (sec == 2'd0);
		base = sec[1] ? m_hmpr[4:0] : m_lmpr[4:0];
		if (ext)
			page = {1'b1, (sec == 2'd2) ? m_extc : m_extd};
		else
			page = {4'b0000, base + 5'(sec[0])};
		return {page, rom0, rom1, wr && !rom0 && !rom1 && !wp && !(ext && m_ext_dis),
			rd && !rom0 && !rom1};
	endfunction

	// PSG and voice bytes doubled then shifted by two, ear at bit 17, SID fully muted
	function automatic logic [15:0] mix_model(input logic [7:0] psg, input logic [7:0] vox,
			input logic ear_bit);
		int sum;
		sum = 1028 * int'(psg) + 1028 * int'(vox) + (ear_bit ? 131072 : 0);
		return 16'(sum >>> 3);
	endfunction

	// ==============================
	// Table building
	// ==============================
	task automatic add_write(input logic [15:0] a, input logic [7:0] d);
		rows.push_back('{OP_WRITE, a, d, 16'h0000});
		case (a[7:0])
			8'hFA: m_lmpr = d;
			8'hFB: m_hmpr = d;
			8'hFE: m_brdr = d;
			8'h80: m_extc = d;
			8'h81: m_extd = d;
			8'hE8: m_lptd = d;
			8'hE9: begin
				if (!m_stb && d[0])
					m_vox_l = m_lptd;
				if (m_stb && !d[0])
					m_vox_r = m_lptd;
				m_stb = d[0];
			end
			default: ;
		endcase
	endtask

	task automatic add_read(input logic [15:0] a, input logic [7:0] exp);
		rows.push_back('{OP_READ, a, 8'h00, {8'h00, exp}});
	endtask

	// rw bit 0 is a read, bit 1 a write
	task automatic probe_sections(input logic [1:0] rw);
		logic [15:0] a;
		for (int s = 0; s < 4; s++) begin
			a = {2'(s), 14'($urandom)};
			rows.push_back('{OP_PROBE, a, {6'd0, rw}, {3'b000, map_model(a, rw[0], rw[1])}});
		end
	endtask

	task automatic add_audio(input logic right, input logic [7:0] psg);
		rows.push_back('{OP_AUDIO, {15'd0, right}, psg,
			mix_model(psg, right ? m_vox_r : m_vox_l, m_brdr[4])});
	endtask

	task automatic add_reset(input logic off);
		rows.push_back('{OP_RESET, 16'h0000, {7'd0, off}, 16'h0000});
		m_lmpr    = '0;
		m_hmpr    = '0;
		m_brdr    = '0;
		m_vox_l   = '0;
		m_vox_r   = '0;
		m_stb     = 1'b0;
		m_ext_dis = off;
	endtask

	// ==============================
	// Stimulus and checks
	// ==============================
	task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("[FAIL] %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic do_write(input logic [15:0] a, input logic [7:0] d);
		bus.addr    = a;
		bus.dout    = d;
		bus.port_we = 1'b1;
		repeat (2) @(negedge clk_sys);
		bus.port_we = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic do_reset(input logic off);
		reset       = 1'b1;
		ext_ram_off = off;
		repeat (8) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic check_midi();
		int   wait_cycles;
		int   high_cycles;
		int   int_rise;
		logic int_seen;
		logic int_last;
		check_eq("midi_int", {15'd0, midi_int}, 16'h0000);
		do_write(16'h00FD, 8'h5A);
		wait_cycles = 4;
		while (!midi_out && wait_cycles < 100) begin
			@(negedge clk_sys);
			wait_cycles++;
		end
		checks++;
		assert (midi_out) else begin
			$display("midi_out did not rise within 100 cycles of the MIDI port write");
			errors++;
		end
		if (midi_out) begin
			bus.addr    = 16'h00F9;
			high_cycles = 1;
			int_rise    = 0;
			int_seen    = 1'b0;
			int_last    = 1'b0;
			@(negedge clk_sys);
			while (midi_out && high_cycles < 32000) begin
				if (!asic_dout[4])
					int_seen = 1'b1;
				if (midi_int && int_rise == 0)
					int_rise = high_cycles;
				int_last = midi_int;
				high_cycles++;
				@(negedge clk_sys);
			end
			checks++;
			// 320 ticks of 96 cycles, one tick of slack
			assert (high_cycles >= 30624 && high_cycles <= 30816) else begin
				$display("[FAIL] midi_out high cycles expected %h got %h", 30720, high_cycles);
				errors++;
			end
			checks++;
			// Interrupt 305 ticks into the byte
			assert (int_rise >= 29184 && int_rise <= 29376) else begin
				$display("[FAIL] midi_int rise cycle expected %h got %h", 29280, int_rise);
				errors++;
			end
			checks++;
			assert (int_last) else begin
				$display("midi_int dropped before midi_out fell");
				errors++;
			end
			checks++;
			assert (int_seen) else begin
				$display("Status port bit 4 never went low while midi_out was high");
				errors++;
			end
			check_eq("midi_int", {15'd0, midi_int}, 16'h0000);
			check_eq("asic_dout", {8'h00, asic_dout}, 16'h00FF);
		end
	endtask

	initial begin
		int         budget;
		logic [7:0] val;
		reset       = 1'b1;
		bus         = '0;
		ext_ram_off = 1'b0;
		psg_l       = '0;
		psg_r       = '0;
		sid_sample  = '0;
		sid_active  = 1'b0;
		checks      = 0;
		errors      = 0;
		budget      = 200;
		void'($urandom(57));
		m_extc = '0;
		m_extd = '0;
		m_lptd = '0;
		add_reset(1'b0);
		rows.delete();

		// Register readback
		val = 8'($urandom);
		add_write(16'h00FA, val);
		add_read(16'h00FA, val);
		val = 8'($urandom);
		add_write(16'h00FB, val);
		add_read(16'h00FB, val);
		add_read(16'h00F9, 8'hFF);
		add_read(16'h0012, 8'hFF);
		add_read(16'h00E8, 8'h00);

		// Paging, plain RAM then ROMs with write protect, then write protect alone
		add_write(16'h00FA, {3'b001, 5'($urandom)});
		add_write(16'h00FB, {3'b000, 5'($urandom)});
		probe_sections(2'b01);
		probe_sections(2'b10);
		add_write(16'h00FA, {3'b110, 5'($urandom)});
		probe_sections(2'b10);
		probe_sections(2'b01);
		add_write(16'h00FA, {3'b101, 5'($urandom)});
		probe_sections(2'b10);

		// External RAM, enabled and then disabled at reset
		add_write(16'h0080, 8'($urandom));
		add_write(16'h0081, 8'($urandom));
		add_write(16'h00FB, {3'b100, 5'($urandom)});
		probe_sections(2'b10);
		probe_sections(2'b01);
		add_reset(1'b1);
		add_write(16'h00FA, {3'b001, 5'($urandom)});
		add_write(16'h00FB, {3'b100, 5'($urandom)});
		probe_sections(2'b10);
		add_reset(1'b0);

		// Voice DAC, mixer with random SID samples and ear
		add_write(16'h00E8, 8'($urandom));
		add_write(16'h00E9, 8'h01);
		add_audio(1'b0, 8'($urandom));
		add_write(16'h00E8, 8'($urandom));
		add_write(16'h00E9, 8'h00);
		add_audio(1'b1, 8'($urandom));
		add_write(16'h00FE, 8'h10);
		add_audio(1'b0, 8'($urandom));
		add_audio(1'b1, 8'($urandom));

		rows.push_back('{OP_MIDI, 16'h00FD, 8'h00, 16'h0000});

		foreach (rows[i])
			budget += (rows[i].op == OP_MIDI) ? 33000 : 16;
		limit_cycles = budget;

		@(negedge clk_sys);
		do_reset(1'b0);
		foreach (rows[i]) begin
			case (rows[i].op)
				OP_WRITE: do_write(rows[i].addr, rows[i].data);
				OP_READ: begin
					bus.addr = rows[i].addr;
					@(negedge clk_sys);
					check_eq("asic_dout", {8'h00, asic_dout}, rows[i].exp);
				end
				OP_PROBE: begin
					bus.addr = rows[i].addr;
					bus.mreq = 1'b1;
					bus.rd   = rows[i].data[0];
					bus.wr   = rows[i].data[1];
					@(negedge clk_sys);
					check_eq("map", {3'b000, map}, rows[i].exp);
					bus.mreq = 1'b0;
					bus.rd   = 1'b0;
					bus.wr   = 1'b0;
				end
				OP_AUDIO: begin
					psg_l      = rows[i].data;
					psg_r      = rows[i].data;
					sid_sample = 18'($urandom);
					@(negedge clk_sys);
					if (rows[i].addr[0])
						check_eq("audio_r", audio_r, rows[i].exp);
					else
						check_eq("audio_l", audio_l, rows[i].exp);
				end
				OP_RESET: do_reset(rows[i].data[0]);
				default:  check_midi();
			endcase
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog, sized once the table is known
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the run did not finish", limit_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
sam_pkg.sv
sam_timebase.sv
asic_ports.sv
mem_mapper.sv
midi_tx.sv
lpt_dac.sv
audio_mixer.sv
sam_io_top.sv
tb_sam_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sam_io -f build.f -o tb_sam_io
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_sam_io > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
